// File: verilog/vmul_pkg.sv
// Shared widths, encodings and the instruction record of the multiply lane.
// One 64-bit word per micro-operation, vl counts elements and not words.
package vmul_pkg;

  typedef logic [63:0] elen_t;
  typedef logic [7:0]  strb_t;
  typedef logic [1:0]  ew_t;
  typedef logic [1:0]  vmul_op_t;
  typedef logic [6:0]  vlen_t;
  typedef logic [1:0]  vid_t;
  typedef logic [4:0]  vreg_t;
  typedef logic [7:0]  vaddr_t;
  typedef logic [3:0]  elem_cnt_t;

  // Element width codes
  localparam ew_t EW8  = 2'd0;
  localparam ew_t EW16 = 2'd1;
  localparam ew_t EW32 = 2'd2;
  localparam ew_t EW64 = 2'd3;

  // Supported integer multiply operations
  localparam vmul_op_t OP_VMUL   = 2'd0;
  localparam vmul_op_t OP_VMULH  = 2'd1;
  localparam vmul_op_t OP_VMULHU = 2'd2;
  localparam vmul_op_t OP_VMACC  = 2'd3;

  // Number of distinct instruction ids in flight
  localparam int unsigned NrVInsn = 4;

  typedef struct packed {
    vmul_op_t op;
    ew_t      vsew;
    vlen_t    vl;
    vreg_t    vd;
    vid_t     id;
    logic     use_scalar;
    elen_t    scalar;
  } vmul_insn_t;

  // Elements packed in one 64-bit word
  function automatic elem_cnt_t words_per_elem_cnt(ew_t vsew);
    case (vsew)
      EW8:     return elem_cnt_t'(8);
      EW16:    return elem_cnt_t'(4);
      EW32:    return elem_cnt_t'(2);
      default: return elem_cnt_t'(1);
    endcase
  endfunction

endpackage

// File: verilog/mul_req_if.sv
// Issue-to-multiplier channel, one word per transfer on valid and ready.
// cnt tags how many elements of the word are live.
`timescale 1ns/1ps

interface mul_req_if import vmul_pkg::*; ();

  logic      valid;
  logic      ready;
  vmul_op_t  op;
  ew_t       vsew;
  elen_t     a;
  elen_t     b;
  elen_t     c;
  elem_cnt_t cnt;

  modport issue (output valid, op, vsew, a, b, c, cnt, input ready);
  modport mul (input valid, op, vsew, a, b, c, cnt, output ready);

endinterface

// File: verilog/vinsn_queue.sv
// In-order instruction queue with issue, processing and commit phases.
// Fullness is decided by the commit count, so a slot frees only at commit.
`timescale 1ns/1ps

module vinsn_queue import vmul_pkg::*; #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  vmul_insn_t insn_i,
  input  logic       insn_valid_i,
  output logic       insn_ready_o,
  output vmul_insn_t issue_insn_o,
  output logic       issue_valid_o,
  input  logic       issue_done_i,
  output vmul_insn_t proc_insn_o,
  output logic       proc_valid_o,
  input  logic       process_done_i,
  output vmul_insn_t commit_insn_o,
  output logic       commit_valid_o,
  input  logic       commit_done_i
);

  localparam int unsigned PtrW = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [PtrW:0]   cnt_t;

  vmul_insn_t insn_q [InsnQueueDepth];

  ptr_t accept_pnt_q, issue_pnt_q, proc_pnt_q, commit_pnt_q;
  cnt_t issue_cnt_q, proc_cnt_q, commit_cnt_q;
  logic accept;

  function automatic ptr_t bump(ptr_t p);
    return (p == ptr_t'(InsnQueueDepth - 1)) ? '0 : p + ptr_t'(1);
  endfunction

  assign insn_ready_o = (commit_cnt_q != cnt_t'(InsnQueueDepth));
  assign accept       = insn_valid_i && insn_ready_o;

  assign issue_insn_o   = insn_q[issue_pnt_q];
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign proc_insn_o    = insn_q[proc_pnt_q];
  assign proc_valid_o   = (proc_cnt_q != '0);
  assign commit_insn_o  = insn_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

  // Instruction storage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= insn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      proc_pnt_q   <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      proc_cnt_q   <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (accept) accept_pnt_q <= bump(accept_pnt_q);
      if (issue_done_i) issue_pnt_q <= bump(issue_pnt_q);
      if (process_done_i) proc_pnt_q <= bump(proc_pnt_q);
      if (commit_done_i) commit_pnt_q <= bump(commit_pnt_q);
      // Every accepted instruction is pending in all three phases
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done_i);
      proc_cnt_q   <= proc_cnt_q + cnt_t'(accept) - cnt_t'(process_done_i);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_done_i);
    end
  end

endmodule

// File: verilog/mul_issue.sv
// Issue stage, sends one word per micro-operation into the multiplier.
// vs2 is always read, vs1 only without a scalar, vd only for VMACC.
`timescale 1ns/1ps

module mul_issue import vmul_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  vmul_insn_t   insn_i,
  input  logic         insn_valid_i,
  input  elen_t  [2:0] operand_i,
  input  logic   [2:0] operand_valid_i,
  output logic   [2:0] operand_ready_o,
  output logic         issue_done_o,
  mul_req_if.issue     req
);

  logic       busy_q;
  vlen_t      cnt_q;
  vlen_t      remaining;
  elem_cnt_t  per_word;
  elem_cnt_t  word_cnt;
  logic [2:0] needed;
  elen_t      scalar_rep;
  logic       fire;

  // Broadcast the scalar into every element of the word
  always_comb begin
    case (insn_i.vsew)
      EW8:     scalar_rep = {8{insn_i.scalar[7:0]}};
      EW16:    scalar_rep = {4{insn_i.scalar[15:0]}};
      EW32:    scalar_rep = {2{insn_i.scalar[31:0]}};
      default: scalar_rep = insn_i.scalar;
    endcase
  end

  // A fresh instruction starts from its full vl
  assign remaining = busy_q ? cnt_q : insn_i.vl;
  assign per_word  = words_per_elem_cnt(insn_i.vsew);
  assign word_cnt  = (vlen_t'(per_word) > remaining) ? elem_cnt_t'(remaining) : per_word;

  // Slot order is vd, vs2, vs1
  assign needed = {insn_i.op == OP_VMACC, 1'b1, !insn_i.use_scalar};

  assign req.valid = insn_valid_i && ((operand_valid_i | ~needed) == 3'b111);
  assign req.op    = insn_i.op;
  assign req.vsew  = insn_i.vsew;
  assign req.a     = insn_i.use_scalar ? scalar_rep : operand_i[0];
  assign req.b     = operand_i[1];
  assign req.c     = operand_i[2];
  assign req.cnt   = word_cnt;

  assign fire            = req.valid && req.ready;
  assign operand_ready_o = fire ? needed : 3'b000;
  assign issue_done_o    = fire && (remaining == vlen_t'(word_cnt));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (fire) begin
      busy_q <= !issue_done_o;
      cnt_q  <= remaining - vlen_t'(word_cnt);
    end
  end

endmodule

// File: verilog/simd_mul.sv
// Pipelined SIMD integer multiplier, same latency for every element width.
// A valid last stage with no downstream ready freezes the whole pipe.
// Lanes beyond the tagged element count come out as zero.
`timescale 1ns/1ps

module simd_mul import vmul_pkg::*; #(
  parameter int unsigned MulLatency = 3
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  mul_req_if.mul req,
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output elen_t out_word_o
);

  elen_t                 data_q [MulLatency];
  logic [MulLatency-1:0] valid_q;
  elen_t                 result;
  int unsigned           lane_w;
  logic                  stall;

  // One lane of width w, operands sit in the low bits
  function automatic elen_t lane_op(elen_t a, elen_t b, elen_t c, vmul_op_t op,
                                    int unsigned w);
    elen_t               mask;
    logic signed [63:0]  sa;
    logic signed [63:0]  sb;
    logic signed [64:0]  xa;
    logic signed [64:0]  xb;
    logic signed [129:0] prod;
    elen_t               lo;
    elen_t               hi;
    mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    sa   = $signed(a << (64 - w)) >>> (64 - w);
    sb   = $signed(b << (64 - w)) >>> (64 - w);
    // Sign extend only for the signed high product
    xa   = (op == OP_VMULH) ? {sa[63], sa} : {1'b0, a & mask};
    xb   = (op == OP_VMULH) ? {sb[63], sb} : {1'b0, b & mask};
    prod = xa * xb;
    lo   = prod[63:0] & mask;
    hi   = elen_t'(prod >> w) & mask;
    case (op)
      OP_VMULH, OP_VMULHU: return hi;
      OP_VMACC:            return (lo + c) & mask;
      default:             return lo;
    endcase
  endfunction

  always_comb begin
    lane_w = 32'd8 << req.vsew;
    result = '0;
    for (int i = 0; i < 8; i++) begin
      if (i < int'(req.cnt)) begin
        result |= lane_op(req.a >> (i * lane_w), req.b >> (i * lane_w),
                          req.c >> (i * lane_w), req.op, lane_w) << (i * lane_w);
      end
    end
  end

  assign stall       = valid_q[MulLatency-1] && !out_ready_i;
  assign req.ready   = !stall;
  assign out_valid_o = valid_q[MulLatency-1];
  assign out_word_o  = data_q[MulLatency-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (!stall) begin
      valid_q[0] <= req.valid;
      for (int s = 1; s < MulLatency; s++) valid_q[s] <= valid_q[s-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      data_q[0] <= result;
      for (int s = 1; s < MulLatency; s++) data_q[s] <= data_q[s-1];
    end
  end

endmodule

// File: verilog/result_queue.sv
// Tags multiplier words with address and byte enables, buffers them and
// writes them back on request/grant. Words arrive in instruction order.
`timescale 1ns/1ps

module result_queue import vmul_pkg::*; #(
  parameter int unsigned ResultQueueDepth = 2,
  parameter int unsigned WordsPerVreg     = 8
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  vmul_insn_t         proc_insn_i,
  input  logic               proc_valid_i,
  output logic               process_done_o,
  input  vmul_insn_t         commit_insn_i,
  input  logic               commit_valid_i,
  output logic               commit_done_o,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  elen_t              in_word_i,
  output logic               result_req_o,
  output vid_t               result_id_o,
  output vaddr_t             result_addr_o,
  output elen_t              result_wdata_o,
  output strb_t              result_be_o,
  input  logic               result_gnt_i,
  output logic [NrVInsn-1:0] insn_done_o
);

  localparam int unsigned PtrW = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } payload_t;

  payload_t        mem_q [ResultQueueDepth];
  logic [PtrW-1:0] wr_pnt_q, rd_pnt_q;
  logic [PtrW:0]   cnt_q;
  logic            push, pop;
  logic            proc_busy_q, commit_busy_q;
  vlen_t           proc_cnt_q, commit_cnt_q;
  vlen_t           proc_left, commit_left, proc_word_idx;
  elem_cnt_t       proc_per_word, proc_n, commit_per_word, commit_n, proc_bytes;
  payload_t        entry;

  // Processing side, elements still expected from the multiplier
  assign proc_left     = proc_busy_q ? proc_cnt_q : proc_insn_i.vl;
  assign proc_per_word = words_per_elem_cnt(proc_insn_i.vsew);
  assign proc_n        = (vlen_t'(proc_per_word) > proc_left) ? elem_cnt_t'(proc_left)
                                                               : proc_per_word;
  assign proc_word_idx = (proc_insn_i.vl - proc_left) >> (2'd3 - proc_insn_i.vsew);
  assign proc_bytes    = elem_cnt_t'(proc_n << proc_insn_i.vsew);

  assign entry.id    = proc_insn_i.id;
  assign entry.addr  = vaddr_t'(proc_insn_i.vd) * vaddr_t'(WordsPerVreg) + vaddr_t'(proc_word_idx);
  assign entry.wdata = in_word_i;
  assign entry.be    = strb_t'((9'd1 << proc_bytes) - 9'd1);

  assign in_ready_o     = (cnt_q != (PtrW+1)'(ResultQueueDepth)) && proc_valid_i;
  assign push           = in_valid_i && in_ready_o;
  assign process_done_o = push && (proc_left == vlen_t'(proc_n));

  // Write-back side
  assign result_req_o   = (cnt_q != '0);
  assign result_id_o    = mem_q[rd_pnt_q].id;
  assign result_addr_o  = mem_q[rd_pnt_q].addr;
  assign result_wdata_o = mem_q[rd_pnt_q].wdata;
  assign result_be_o    = mem_q[rd_pnt_q].be;
  assign pop            = result_req_o && result_gnt_i;

  assign commit_left     = commit_busy_q ? commit_cnt_q : commit_insn_i.vl;
  assign commit_per_word = words_per_elem_cnt(commit_insn_i.vsew);
  assign commit_n        = (vlen_t'(commit_per_word) > commit_left) ? elem_cnt_t'(commit_left)
                                                                     : commit_per_word;
  assign commit_done_o   = pop && commit_valid_i && (commit_left == vlen_t'(commit_n));

  always_comb begin
    insn_done_o                   = '0;
    insn_done_o[commit_insn_i.id] = commit_done_o;
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_pnt_q] <= entry;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q      <= '0;
      rd_pnt_q      <= '0;
      cnt_q         <= '0;
      proc_busy_q   <= 1'b0;
      proc_cnt_q    <= '0;
      commit_busy_q <= 1'b0;
      commit_cnt_q  <= '0;
    end else begin
      if (push) begin
        wr_pnt_q    <= (wr_pnt_q == PtrW'(ResultQueueDepth - 1)) ? '0 : wr_pnt_q + 1'b1;
        proc_busy_q <= !process_done_o;
        proc_cnt_q  <= proc_left - vlen_t'(proc_n);
      end
      if (pop) begin
        rd_pnt_q      <= (rd_pnt_q == PtrW'(ResultQueueDepth - 1)) ? '0 : rd_pnt_q + 1'b1;
        commit_busy_q <= !commit_done_o;
        commit_cnt_q  <= commit_left - vlen_t'(commit_n);
      end
      cnt_q <= cnt_q + (PtrW+1)'(push) - (PtrW+1)'(pop);
    end
  end

endmodule

// File: verilog/vmul_unit.sv
// Integer multiply path of one vector lane, all instructions unmasked.
// Done pulses come in acceptance order, one per instruction id.
`timescale 1ns/1ps

module vmul_unit import vmul_pkg::*; #(
  parameter int unsigned InsnQueueDepth   = 4,
  parameter int unsigned ResultQueueDepth = 2,
  parameter int unsigned MulLatency       = 3,
  parameter int unsigned WordsPerVreg     = 8
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  vmul_op_t           insn_op_i,
  input  ew_t                insn_vsew_i,
  input  vlen_t              insn_vl_i,
  input  vreg_t              insn_vd_i,
  input  vid_t               insn_id_i,
  input  logic               insn_use_scalar_i,
  input  elen_t              insn_scalar_i,
  input  logic               insn_valid_i,
  output logic               insn_ready_o,
  input  elen_t  [2:0]       operand_i,
  input  logic   [2:0]       operand_valid_i,
  output logic   [2:0]       operand_ready_o,
  output logic               result_req_o,
  output vid_t               result_id_o,
  output vaddr_t             result_addr_o,
  output elen_t              result_wdata_o,
  output strb_t              result_be_o,
  input  logic               result_gnt_i,
  output logic [NrVInsn-1:0] insn_done_o
);

  vmul_insn_t insn, issue_insn, proc_insn, commit_insn;
  logic       issue_valid, proc_valid, commit_valid;
  logic       issue_done, process_done, commit_done;
  logic       mul_out_valid, mul_out_ready;
  elen_t      mul_out_word;

  assign insn = '{op: insn_op_i, vsew: insn_vsew_i, vl: insn_vl_i, vd: insn_vd_i,
                  id: insn_id_i, use_scalar: insn_use_scalar_i, scalar: insn_scalar_i};

  mul_req_if mul_req ();

  vinsn_queue #(.InsnQueueDepth(InsnQueueDepth)) i_vinsn_queue (
    .clk_i, .rst_ni,
    .insn_i(insn), .insn_valid_i, .insn_ready_o,
    .issue_insn_o(issue_insn), .issue_valid_o(issue_valid), .issue_done_i(issue_done),
    .proc_insn_o(proc_insn), .proc_valid_o(proc_valid), .process_done_i(process_done),
    .commit_insn_o(commit_insn), .commit_valid_o(commit_valid), .commit_done_i(commit_done)
  );

  mul_issue i_mul_issue (
    .clk_i, .rst_ni,
    .insn_i(issue_insn), .insn_valid_i(issue_valid),
    .operand_i, .operand_valid_i, .operand_ready_o,
    .issue_done_o(issue_done), .req(mul_req.issue)
  );

  simd_mul #(.MulLatency(MulLatency)) i_simd_mul (
    .clk_i, .rst_ni, .req(mul_req.mul),
    .out_valid_o(mul_out_valid), .out_ready_i(mul_out_ready), .out_word_o(mul_out_word)
  );

  result_queue #(
    .ResultQueueDepth(ResultQueueDepth),
    .WordsPerVreg    (WordsPerVreg)
  ) i_result_queue (
    .clk_i, .rst_ni,
    .proc_insn_i(proc_insn), .proc_valid_i(proc_valid), .process_done_o(process_done),
    .commit_insn_i(commit_insn), .commit_valid_i(commit_valid), .commit_done_o(commit_done),
    .in_valid_i(mul_out_valid), .in_ready_o(mul_out_ready), .in_word_i(mul_out_word),
    .result_req_o, .result_id_o, .result_addr_o, .result_wdata_o, .result_be_o,
    .result_gnt_i, .insn_done_o
  );

endmodule

// File: dv/tb_vmul_model.svh
// Reference model of the multiply lane, included inside the testbench module.
// Expects WordsPerVreg to be declared before the include.
`ifndef TB_VMUL_MODEL_SVH
`define TB_VMUL_MODEL_SVH

typedef struct packed {
  vid_t   id;
  vaddr_t addr;
  elen_t  wdata;
  strb_t  be;
  logic   last;
} exp_word_t;

// Expected writes and acknowledges, both in acceptance order
exp_word_t  exp_q [$];
logic [2:0] ack_q [$];
vid_t       done_q [$];
// Operand words per slot, in the order the DUT should consume them
elen_t      slot_q [3][$];

function automatic elen_t next_operand(int s);
  elen_t v;
  v = {$urandom, $urandom};
  slot_q[s].push_back(v);
  return v;
endfunction

function automatic elen_t replicate(elen_t s, int w);
  elen_t r;
  elen_t m;
  m = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
  r = '0;
  for (int i = 0; i < 64 / w; i++) r |= (s & m) << (i * w);
  return r;
endfunction

function automatic elen_t byte_mask(strb_t be);
  elen_t m;
  for (int i = 0; i < 8; i++) m[i*8 +: 8] = {8{be[i]}};
  return m;
endfunction

// Per lane products computed on 128 bits, wide enough for any width
function automatic elen_t expected_word(vmul_op_t op, int w, int n, elen_t a, elen_t b,
                                        elen_t c);
  logic [127:0] mask;
  logic [127:0] xa;
  logic [127:0] xb;
  logic [127:0] xc;
  logic [127:0] prod;
  elen_t        lane;
  elen_t        res;
  res  = '0;
  mask = (128'd1 << w) - 128'd1;
  for (int i = 0; i < n; i++) begin
    xa = ({64'd0, a} >> (i * w)) & mask;
    xb = ({64'd0, b} >> (i * w)) & mask;
    xc = ({64'd0, c} >> (i * w)) & mask;
    if (op == OP_VMULH) begin
      if (xa[w-1]) xa |= ~mask;
      if (xb[w-1]) xb |= ~mask;
    end
    prod = xa * xb;
    case (op)
      OP_VMULH, OP_VMULHU: lane = elen_t'((prod >> w) & mask);
      OP_VMACC:            lane = elen_t'((prod + xc) & mask);
      default:             lane = elen_t'(prod & mask);
    endcase
    res |= lane << (i * w);
  end
  return res;
endfunction

task automatic model_insn(input vmul_insn_t insn);
  int         w;
  int         per;
  int         words;
  int         left;
  int         n;
  elen_t      a;
  elen_t      b;
  elen_t      c;
  logic [2:0] need;
  exp_word_t  e;
  w     = 8 << insn.vsew;
  per   = 64 / w;
  words = (int'(insn.vl) + per - 1) / per;
  left  = int'(insn.vl);
  // Slots are vs1, vs2, vd from bit 0 upward
  need  = {insn.op == OP_VMACC, 1'b1, !insn.use_scalar};
  for (int k = 0; k < words; k++) begin
    n = (left < per) ? left : per;
    a = need[0] ? next_operand(0) : replicate(insn.scalar, w);
    b = next_operand(1);
    c = need[2] ? next_operand(2) : '0;
    e.id    = insn.id;
    e.addr  = vaddr_t'(int'(insn.vd) * WordsPerVreg + k);
    e.wdata = expected_word(insn.op, w, n, a, b, c);
    e.be    = strb_t'((1 << (n * w / 8)) - 1);
    e.last  = (k == words - 1);
    exp_q.push_back(e);
    ack_q.push_back(need);
    left -= n;
  end
  done_q.push_back(insn.id);
endtask

`endif

// File: dv/tb_vmul_unit.sv
// Random-stimulus testbench for the vector multiply lane, fixed seed.
// Every written word, operand acknowledge and done pulse is checked
// against the model; the run stops at the first error.
`timescale 1ns/1ps

module tb_vmul_unit import vmul_pkg::*; ();

  localparam int unsigned NumInsn        = 80;
  localparam int unsigned InsnQueueDepth = 4;
  localparam int unsigned WordsPerVreg   = 8;
  localparam int unsigned TimeoutCycles  = 200 * NumInsn + 1000;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  vmul_insn_t         cur;
  logic               insn_valid;
  logic               insn_ready;
  elen_t  [2:0]       operand;
  logic   [2:0]       operand_valid;
  logic   [2:0]       operand_ready;
  logic               result_req;
  vid_t               result_id;
  vaddr_t             result_addr;
  elen_t              result_wdata;
  strb_t              result_be;
  logic               result_gnt;
  logic [NrVInsn-1:0] insn_done;

  `include "tb_vmul_model.svh"

  int unsigned        seed_val;
  int unsigned        cycles;
  int unsigned        offered;
  int unsigned        acc_cnt;
  int unsigned        done_cnt;
  int unsigned        gap_left;
  int unsigned        idx [3];
  logic [NrVInsn-1:0] id_busy;
  logic               acc_fire;
  logic               saw_full;
  logic [2:0]         slot_fire;
  // Payload of a request still waiting for its grant
  logic               held;
  vid_t               h_id;
  vaddr_t             h_addr;
  elen_t              h_wdata;
  strb_t              h_be;

  always #5 clk_i = ~clk_i;

  vmul_unit #(
    .InsnQueueDepth  (InsnQueueDepth),
    .ResultQueueDepth(2),
    .MulLatency      (3),
    .WordsPerVreg    (WordsPerVreg)
  ) DUT (
    .clk_i, .rst_ni,
    .insn_op_i(cur.op), .insn_vsew_i(cur.vsew), .insn_vl_i(cur.vl), .insn_vd_i(cur.vd),
    .insn_id_i(cur.id), .insn_use_scalar_i(cur.use_scalar), .insn_scalar_i(cur.scalar),
    .insn_valid_i(insn_valid), .insn_ready_o(insn_ready),
    .operand_i(operand), .operand_valid_i(operand_valid), .operand_ready_o(operand_ready),
    .result_req_o(result_req), .result_id_o(result_id), .result_addr_o(result_addr),
    .result_wdata_o(result_wdata), .result_be_o(result_be), .result_gnt_i(result_gnt),
    .insn_done_o(insn_done)
  );

  task automatic stop_run(string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) stop_run($sformatf("mismatch at %0t: %s got %b expected %b",
                                        $time, name, got, exp));
  endtask

  task automatic check_ack(string name, logic [2:0] got, logic [2:0] exp);
    if (got !== exp) stop_run($sformatf("mismatch at %0t: %s got %b expected %b",
                                        $time, name, got, exp));
  endtask

  task automatic check_done(string name, logic [NrVInsn-1:0] got, logic [NrVInsn-1:0] exp);
    if (got !== exp) stop_run($sformatf("mismatch at %0t: %s got %b expected %b",
                                        $time, name, got, exp));
  endtask

  task automatic check_id(string name, vid_t got, vid_t exp);
    if (got !== exp) stop_run($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                        $time, name, got, exp));
  endtask

  task automatic check_addr(string name, vaddr_t got, vaddr_t exp);
    if (got !== exp) stop_run($sformatf("mismatch at %0t: %s got %h expected %h",
                                        $time, name, got, exp));
  endtask

  task automatic check_be(string name, strb_t got, strb_t exp);
    if (got !== exp) stop_run($sformatf("mismatch at %0t: %s got %b expected %b",
                                        $time, name, got, exp));
  endtask

  task automatic check_word(string name, elen_t got, elen_t exp);
    if (got !== exp) stop_run($sformatf("mismatch at %0t: %s got %h expected %h",
                                        $time, name, got, exp));
  endtask

  task automatic offer_insn();
    vmul_insn_t  insn;
    int unsigned per;
    int unsigned k;
    insn = '0;
    if (offered < 32) begin
      // Sweep every op and width, first with vs1 and then with the scalar
      insn.op         = vmul_op_t'(offered % 4);
      insn.vsew       = ew_t'((offered / 4) % 4);
      insn.use_scalar = (offered >= 16);
    end else begin
      insn.op         = vmul_op_t'($urandom % 4);
      insn.vsew       = ew_t'($urandom % 4);
      insn.use_scalar = $urandom % 2;
    end
    per         = 8 >> insn.vsew;
    insn.vl     = vlen_t'(1 + $urandom % (per * WordsPerVreg));
    insn.vd     = vreg_t'($urandom % 32);
    insn.scalar = {$urandom, $urandom};
    // Free id, scanning from a random start
    k = $urandom % NrVInsn;
    while (id_busy[k]) k = (k + 1) % NrVInsn;
    insn.id     = vid_t'(k);
    id_busy[k]  = 1'b1;
    model_insn(insn);
    cur        = insn;
    insn_valid = 1'b1;
    offered++;
  endtask

  // Called 1 ns after the rising edge
  task automatic drive_inputs();
    if (acc_fire) insn_valid = 1'b0;
    if (!insn_valid && offered < NumInsn && id_busy != '1 && $urandom % 4 != 0) begin
      offer_insn();
    end
    for (int s = 0; s < 3; s++) begin
      if (slot_fire[s]) idx[s]++;
      operand_valid[s] = (idx[s] < slot_q[s].size()) && ($urandom % 4 != 0);
      operand[s]       = operand_valid[s] ? slot_q[s][idx[s]] : '0;
    end
    if (gap_left != 0) begin
      result_gnt = 1'b0;
      gap_left--;
    end else if ($urandom % 50 == 0) begin
      // Long write-back stall
      gap_left   = 8 + $urandom % 40;
      result_gnt = 1'b0;
    end else begin
      result_gnt = ($urandom % 3 != 0);
    end
  endtask

  // Called at the falling edge, where inputs and outputs are settled
  task automatic sample_outputs();
    exp_word_t          e;
    vid_t               done_id;
    logic [NrVInsn-1:0] exp_done;
    exp_done = '0;
    check_bit("insn_ready_o", insn_ready, (acc_cnt - done_cnt) != InsnQueueDepth);
    if (!insn_ready) saw_full = 1'b1;
    acc_fire  = insn_valid && insn_ready;
    slot_fire = operand_ready & operand_valid;
    if (operand_ready != 3'b000) begin
      if (ack_q.size() == 0) stop_run("operands acknowledged with no word left to issue");
      check_ack("operand_ready_o", operand_ready, ack_q.pop_front());
    end
    if (result_req) begin
      if (held) begin
        check_id("result_id_o", result_id, h_id);
        check_addr("result_addr_o", result_addr, h_addr);
        check_word("result_wdata_o", result_wdata, h_wdata);
        check_be("result_be_o", result_be, h_be);
      end
      if (result_gnt) begin
        if (exp_q.size() == 0) stop_run("result written with no word expected");
        e = exp_q.pop_front();
        check_id("result_id_o", result_id, e.id);
        check_addr("result_addr_o", result_addr, e.addr);
        check_be("result_be_o", result_be, e.be);
        check_word("result_wdata_o", result_wdata & byte_mask(e.be), e.wdata & byte_mask(e.be));
        if (e.last) begin
          // Done ids follow acceptance order
          done_id           = done_q.pop_front();
          exp_done[done_id] = 1'b1;
        end
        held = 1'b0;
      end else begin
        held    = 1'b1;
        h_id    = result_id;
        h_addr  = result_addr;
        h_wdata = result_wdata;
        h_be    = result_be;
      end
    end else if (held) begin
      stop_run("result_req_o dropped before its grant");
    end
    check_done("insn_done_o", insn_done, exp_done);
    if (exp_done != '0) begin
      done_cnt++;
      id_busy &= ~exp_done;
    end
    if (acc_fire) acc_cnt++;
  endtask

  initial begin
    string why;
    cur           = '0;
    insn_valid    = 1'b0;
    operand       = '0;
    operand_valid = '0;
    result_gnt    = 1'b0;
    rst_ni        = 1'b0;
    cycles        = 0;
    offered       = 0;
    acc_cnt       = 0;
    done_cnt      = 0;
    gap_left      = 0;
    id_busy       = '0;
    acc_fire      = 1'b0;
    saw_full      = 1'b0;
    slot_fire     = '0;
    held          = 1'b0;
    for (int s = 0; s < 3; s++) idx[s] = 0;
    seed_val = $urandom(9423);
    repeat (15) @(posedge clk_i);
    @(negedge clk_i);
    check_bit("insn_ready_o", insn_ready, 1'b1);
    check_ack("operand_ready_o", operand_ready, 3'b000);
    check_bit("result_req_o", result_req, 1'b0);
    check_done("insn_done_o", insn_done, '0);
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    drive_inputs();
    while (done_cnt < NumInsn) begin
      @(negedge clk_i);
      sample_outputs();
      @(posedge clk_i);
      #1;
      drive_inputs();
      cycles++;
      if (cycles > TimeoutCycles) begin
        stop_run($sformatf("timeout after %0d cycles with %0d of %0d instructions done",
                           cycles, done_cnt, NumInsn));
      end
    end
    why = "";
    if (exp_q.size() != 0) why = "words still expected after the last done pulse";
    for (int s = 0; s < 3; s++) begin
      if (idx[s] != slot_q[s].size()) begin
        why = $sformatf("operand slot %0d consumed %0d of %0d words",
                        s, idx[s], slot_q[s].size());
      end
    end
    if (!saw_full) why = "insn_ready_o never dropped with four instructions pending";
    if (why == "") begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_run(why);
    end
  end

endmodule

// File: all.f
+incdir+dv
verilog/vmul_pkg.sv
verilog/mul_req_if.sv
verilog/vinsn_queue.sv
verilog/mul_issue.sv
verilog/simd_mul.sv
verilog/result_queue.sv
verilog/vmul_unit.sv
dv/tb_vmul_unit.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for a failure
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_vmul_unit -o vsim
./obj_dir/vsim > sim.log 2>&1 || true
cat sim.log
if grep -q "TB FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
exit 0
